//--- verilog.f
rtl/video_pkg.sv
rtl/video_crtc.sv
rtl/video_fetch.sv
rtl/video_dotgen.sv
rtl/video.sv
verification/vmem_model.sv
verification/video_tb.sv

//--- Makefile
# Verilator build for the PET video section

TOP_TB  := video_tb
TOP_RTL := video

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP_RTL)
	verilator --lint-only --timing -f verilog.f --top-module $(TOP_TB)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP_TB) -Mdir obj_dir
	./obj_dir/V$(TOP_TB) | tee sim.log
	@if grep -q "Test failures found" sim.log; then exit 1; fi
	@grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/video_tb.sv
// ==========================================================
// Four random register setups of two frames each on both CRT types
// Model tracks the raster and predicts every pixel and sync
// ==========================================================
`timescale 1ns/1ps

module video_tb;
    import video_pkg::*;

    logic      wb_clock;
    logic      rst_n;
    logic      char_en = 1'b0;
    logic      pixel_en = 1'b0;
    logic      config_crt;
    logic      graphic;
    reg_addr_t wbs_adr;
    data_t     wbs_dat_w;
    data_t     wbs_dat_r;
    logic      wbs_we, wbs_cyc, wbs_stb, wbs_ack;
    wb_addr_t  wbm_adr;
    data_t     wbm_dat;
    logic      wbm_we, wbm_cyc, wbm_stb, wbm_ack;
    logic      h_sync, v_sync, video_out;

    data_t vram_m [1024];        // Model copies of the memories
    data_t vrom_m [4096];
    int    h_tot, h_disp, hs_pos, hs_w, v_tot, v_disp, vs_pos, max_scan, start_addr;
    int    m_h, m_ra, m_row, m_ma, m_rs, m_vs, frames;     // Model raster position
    int    p_h, p_ra, p_row, p_ma, p_vs;                   // Position now on the pixels
    logic  run_en;
    int    cyc_cnt;
    int    last_phase = -1;
    int    edges, reads, char_idx, last_rise;
    logic  hs_last;
    data_t exp_font;
    logic  exp_rev, exp_inv, exp_en;
    int    err_model = 0;
    int    err_prog;

    video u_dut (
        .wb_clock_i(wb_clock), .rst_n_i(rst_n), .char_clk_en_i(char_en),
        .pixel_clk_en_i(pixel_en), .config_crt_i(config_crt), .graphic_i(graphic),
        .wbs_adr_i(wbs_adr), .wbs_dat_i(wbs_dat_w), .wbs_we_i(wbs_we), .wbs_cyc_i(wbs_cyc),
        .wbs_stb_i(wbs_stb), .wbs_dat_o(wbs_dat_r), .wbs_ack_o(wbs_ack),
        .wbm_adr_o(wbm_adr), .wbm_we_o(wbm_we), .wbm_cyc_o(wbm_cyc), .wbm_stb_o(wbm_stb),
        .wbm_dat_i(wbm_dat), .wbm_ack_i(wbm_ack),
        .h_sync_o(h_sync), .v_sync_o(v_sync), .video_o(video_out)
    );

    vmem_model u_mem (
        .wb_clock_i(wb_clock), .rst_n_i(rst_n), .adr_i(wbm_adr), .dat_o(wbm_dat),
        .we_i(wbm_we), .cyc_i(wbm_cyc), .stb_i(wbm_stb), .ack_o(wbm_ack)
    );

    initial begin
        wb_clock = 1'b0;
        forever #10 wb_clock = ~wb_clock;                   // 50 MHz
    end

    // One character step of the 6845 counting rules
    task automatic advance_model();
        int next_row;
        if (m_h != h_tot) begin
            m_h++;
            m_ma = (m_ma + 1) & 14'h3fff;
        end else begin
            m_h = 0;
            next_row = (m_row == v_tot) ? 0 : m_row + 1;
            if (m_ra == max_scan && next_row == vs_pos) m_vs = 16;
            else if (m_vs != 0) m_vs--;
            if (m_ra != max_scan) begin
                m_ra++;
                m_ma = m_rs;                                // Same row again
            end else begin
                m_ra  = 0;
                m_row = next_row;
                if (next_row == 0) begin
                    m_rs = start_addr;                      // New frame
                    frames++;
                end else begin
                    m_rs = (m_rs + h_disp) & 14'h3fff;
                end
                m_ma = m_rs;
            end
        end
    endtask

    // Checks the DUT state left by the posedge of character phase ph
    task automatic check_phase(input int ph);
        logic [13:0] ma_v;
        logic [11:0] rom_idx;
        data_t       code;
        logic        exp_hs, exp_pix, hs_act;
        if (ph == 0) begin
            p_h   = m_h;
            p_ra  = m_ra;
            p_row = m_row;
            p_ma  = m_ma;
            p_vs  = m_vs;
            advance_model();
            edges++;
            char_idx++;
            exp_hs = (p_h >= hs_pos) && (p_h < hs_pos + hs_w);
            if (h_sync !== (exp_hs ^ config_crt)) begin
                $display("** Error: h_sync_o expected %h got %h", exp_hs ^ config_crt, h_sync);
                err_model++;
            end
            if (v_sync !== ((p_vs != 0) ^ config_crt)) begin
                $display("** Error: v_sync_o expected %h got %h",
                         (p_vs != 0) ^ config_crt, v_sync);
                err_model++;
            end
            hs_act = h_sync ^ config_crt;
            if (hs_act && !hs_last) begin
                if (last_rise >= 0 && char_idx - last_rise != h_tot + 1) begin
                    $display("h_sync_o period was %0d characters, not %0d",
                             char_idx - last_rise, h_tot + 1);
                    err_model++;
                end
                last_rise = char_idx;
            end
            hs_last = hs_act;
            if (edges > 1 && reads != 2) begin
                $display("Character time held %0d master reads instead of 2", reads);
                err_model++;
            end
            reads   = 0;
            ma_v    = p_ma[13:0];
            code    = vram_m[ma_v[9:0]];
            rom_idx = {ma_v[13], graphic, code[6:0], p_ra[2:0]};
            exp_font = vrom_m[rom_idx];
            exp_rev  = code[7];
            exp_inv  = ma_v[12];
            exp_en   = (p_h < h_disp) && (p_row < v_disp) && (p_ra < 8);   // Font has 8 lines
        end
        if (ph % 2 == 0 && edges > 1) begin
            exp_pix = (exp_en & (exp_font[7 - ph / 2] ^ exp_rev ^ ~exp_inv)) ^ config_crt;
            if (video_out !== exp_pix) begin
                $display("** Error: video_o expected %h got %h (char %0d pixel %0d)",
                         exp_pix, video_out, char_idx, ph / 2);
                err_model++;
            end
        end
    endtask

    task automatic check_bus();
        if (wbm_stb && !wbm_cyc) begin
            $display("Master raised stb without cyc");
            err_model++;
        end
        if (wbm_we) begin
            $display("** Error: wbm_we_o expected 0 got %h", wbm_we);
            err_model++;
        end
        if (wbm_stb && !(wbm_adr inside {[16'h8000:16'h83ff], [16'hc000:16'hcfff]})) begin
            $display("** Error: wbm_adr_o outside VRAM and ROM, got %h", wbm_adr);
            err_model++;
        end
        if (wbm_stb && wbm_ack) reads++;
    endtask

    // Enables and checks on falling edges with 16 clocks per character
    always @(negedge wb_clock) begin
        if (last_phase >= 0) check_phase(last_phase);
        if (rst_n) check_bus();
        if (run_en) begin
            char_en    <= (cyc_cnt % 16 == 0);
            pixel_en   <= (cyc_cnt % 2 == 1);
            last_phase = cyc_cnt % 16;
            cyc_cnt++;
        end else begin
            char_en    <= 1'b0;
            pixel_en   <= 1'b0;
            last_phase = -1;
            cyc_cnt = 0;
            m_h = 0;
            m_ra = 0;
            m_row = 0;
            m_ma = 0;
            m_rs = 0;
            m_vs = 0;
            frames = 0;
            edges = 0;
            reads = 0;
            char_idx = 0;
            last_rise = -1;
            hs_last = 1'b0;
        end
    end

    task automatic finish_run();
        $display("Errors: %0d in raster and bus checks, %0d in register checks",
                 err_model, err_prog);
        if (err_model + err_prog == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic slave_access(input reg_addr_t a, input logic we, input data_t d,
                                output data_t rd);
        int n;
        n = 0;
        @(negedge wb_clock);
        wbs_adr   = a;
        wbs_dat_w = d;
        wbs_we    = we;
        wbs_cyc   = 1'b1;
        wbs_stb   = 1'b1;
        do begin
            @(negedge wb_clock);
            n++;
        end while (!wbs_ack && n < 20);
        if (!wbs_ack) begin
            $display("Timed out waiting for the slave ack at register %0d", a);
            err_prog++;
            finish_run();
        end else begin
            rd = wbs_dat_r;
            @(negedge wb_clock);                            // Held through the ack edge
            wbs_cyc = 1'b0;
            wbs_stb = 1'b0;
            wbs_we  = 1'b0;
        end
    endtask

    task automatic read_check(input reg_addr_t a, input data_t exp);
        data_t rd;
        slave_access(a, 1'b0, 8'h00, rd);
        if (rd !== exp) begin
            $display("** Error: wbs_dat_o reg %0d expected %h got %h", a, exp, rd);
            err_prog++;
        end
    endtask

    task automatic run_config(input logic crt, input logic inv);
        data_t regs [10];
        data_t rd;
        reg_addr_t idx [10];
        int n;
        config_crt = crt;
        graphic = 1'($urandom % 2);
        rst_n = 1'b0;
        repeat (10) @(negedge wb_clock);
        rst_n = 1'b1;
        @(negedge wb_clock);
        if (h_sync !== crt || v_sync !== crt || video_out !== crt || wbm_cyc !== 1'b0) begin
            $display("Outputs after reset are not idle for the selected CRT");
            err_prog++;
        end
        h_tot  = 10 + $urandom % 8;
        h_disp = 4 + $urandom % (h_tot - 5);
        hs_w   = 1 + $urandom % 3;
        hs_pos = h_disp + $urandom % (h_tot + 2 - h_disp - hs_w);
        v_tot  = 2 + $urandom % 3;
        v_disp = 1 + $urandom % v_tot;
        vs_pos = $urandom % (v_tot + 1);
        max_scan = 9;
        idx = '{R_H_TOTAL, R_H_DISPLAYED, R_H_SYNC_POS, R_SYNC_WIDTH, R_V_TOTAL,
                R_V_DISPLAYED, R_V_SYNC_POS, R_MAX_SCAN, R_START_HI, R_START_LO};
        regs[0] = 8'(h_tot);
        regs[1] = 8'(h_disp);
        regs[2] = 8'(hs_pos);
        regs[3] = {4'($urandom), 4'(hs_w)};                 // Upper nibble unused
        regs[4] = 8'(v_tot);
        regs[5] = 8'(v_disp);
        regs[6] = 8'(vs_pos);
        regs[7] = 8'(max_scan);
        regs[8] = (8'($urandom) & 8'hef) | {3'b000, inv, 4'h0};   // Bit 4 is ma bit 12
        regs[9] = 8'($urandom);
        start_addr = {regs[8][5:0], regs[9]};
        for (int i = 0; i < 10; i++) slave_access(idx[i], 1'b1, regs[i], rd);
        slave_access(5'd5, 1'b1, 8'($urandom), rd);        // Unused index
        for (int i = 0; i < 10; i++) read_check(idx[i], regs[i]);
        read_check(5'd5, 8'h00);
        read_check(5'd20, 8'h00);
        run_en = 1'b1;
        n = 0;
        do begin
            @(negedge wb_clock);
            n++;
        end while (frames < 2 && n < 300000);
        if (frames < 2) begin
            $display("Timed out waiting for two frames");
            err_prog++;
            finish_run();
        end else begin
            run_en = 1'b0;
            repeat (2) @(negedge wb_clock);                 // Last pixel check runs first
        end
    endtask

    initial begin
        data_t b;
        rst_n = 1'b0;
        run_en = 1'b0;
        config_crt = 1'b0;
        graphic = 1'b0;
        wbs_adr = '0;
        wbs_dat_w = '0;
        wbs_we = 1'b0;
        wbs_cyc = 1'b0;
        wbs_stb = 1'b0;
        err_prog = 0;
        void'($urandom(32'hfa61_96b8));
        for (int i = 0; i < 1024; i++) begin
            b = 8'($urandom);
            vram_m[i] = b;
            u_mem.vram[i] = b;
        end
        for (int i = 0; i < 4096; i++) begin
            b = 8'($urandom);
            vrom_m[i] = b;
            u_mem.vrom[i] = b;
        end
        run_config(1'b0, 1'b0);
        run_config(1'b1, 1'b1);
        run_config(1'b0, 1'b1);
        run_config(1'b1, 1'b0);
        finish_run();
    end

endmodule

//--- verification/vmem_model.sv
// ==========================================================
// Wishbone classic read slave, VRAM at 8000h and ROM at C000h
// Acks after 0 to 3 random wait cycles, writes are ignored
// ==========================================================
`timescale 1ns/1ps

module vmem_model (
    input  logic                wb_clock_i,
    input  logic                rst_n_i,
    input  video_pkg::wb_addr_t adr_i,
    output video_pkg::data_t    dat_o,
    input  logic                we_i,
    input  logic                cyc_i,
    input  logic                stb_i,
    output logic                ack_o
);
    import video_pkg::*;

    data_t      vram [1024];     // Loaded by the testbench
    data_t      vrom [4096];
    logic       busy;            // Wait states running
    logic [1:0] wait_cnt;
    logic [1:0] delay;

    // Unmapped addresses read zero
    function automatic data_t read_byte(input wb_addr_t a);
        if (a[15:10] == 6'b100000) begin
            return vram[a[9:0]];
        end else if (a[15:12] == 4'hC) begin
            return vrom[a[11:0]];
        end
        return 8'h00;
    endfunction

    always @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o    <= 1'b0;
            dat_o    <= '0;
            busy     <= 1'b0;
            wait_cnt <= '0;
        end else begin
            ack_o <= 1'b0;                                  // Ack lasts one cycle
            if (cyc_i && stb_i && !ack_o && !we_i) begin
                if (!busy) begin
                    delay = 2'($urandom % 4);               // New request
                    if (delay == 2'd0) begin
                        ack_o <= 1'b1;
                        dat_o <= read_byte(adr_i);
                    end else begin
                        busy     <= 1'b1;
                        wait_cnt <= delay - 2'd1;
                    end
                end else if (wait_cnt == 2'd0) begin
                    ack_o <= 1'b1;
                    busy  <= 1'b0;
                    dat_o <= read_byte(adr_i);
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

//--- rtl/video.sv
// ==========================================================
// PET video, 40-column mode only
// Pixel and character enables come from the clock generator
// ==========================================================
`timescale 1ns/1ps

module video (
    input  logic                 wb_clock_i,
    input  logic                 rst_n_i,
    input  logic                 char_clk_en_i,   // At least 12 clocks apart
    input  logic                 pixel_clk_en_i,  // 8 per character
    input  logic                 config_crt_i,    // 0 is 12-inch, 1 is 9-inch
    input  logic                 graphic_i,
    input  video_pkg::reg_addr_t wbs_adr_i,
    input  video_pkg::data_t     wbs_dat_i,
    input  logic                 wbs_we_i,
    input  logic                 wbs_cyc_i,
    input  logic                 wbs_stb_i,
    output video_pkg::data_t     wbs_dat_o,
    output logic                 wbs_ack_o,
    output video_pkg::wb_addr_t  wbm_adr_o,
    output logic                 wbm_we_o,
    output logic                 wbm_cyc_o,
    output logic                 wbm_stb_o,
    input  video_pkg::data_t     wbm_dat_i,
    input  logic                 wbm_ack_i,
    output logic                 h_sync_o,
    output logic                 v_sync_o,
    output logic                 video_o
);

    logic             de;
    video_pkg::ma_t   ma;
    video_pkg::ra_t   ra;
    logic             crtc_h_sync;   // Active high from the CRTC
    logic             crtc_v_sync;
    video_pkg::data_t font;
    logic             reverse;
    logic             invert;

    video_crtc u_crtc (
        .wb_clock_i, .rst_n_i, .char_clk_en_i,
        .wbs_adr_i, .wbs_dat_i, .wbs_dat_o, .wbs_we_i, .wbs_cyc_i, .wbs_stb_i, .wbs_ack_o,
        .de_o(de), .ma_o(ma), .ra_o(ra),
        .h_sync_o(crtc_h_sync), .v_sync_o(crtc_v_sync)
    );

    video_fetch u_fetch (
        .wb_clock_i, .rst_n_i, .char_clk_en_i, .graphic_i,
        .ma_i(ma), .ra_i(ra),
        .wbm_adr_o, .wbm_dat_i, .wbm_we_o, .wbm_cyc_o, .wbm_stb_o, .wbm_ack_i,
        .font_o(font), .reverse_o(reverse), .invert_o(invert)
    );

    video_dotgen u_dotgen (
        .wb_clock_i, .rst_n_i, .char_clk_en_i, .pixel_clk_en_i, .config_crt_i,
        .font_i(font), .reverse_i(reverse), .invert_i(invert),
        .de_i(de), .ra_i(ra), .h_sync_i(crtc_h_sync), .v_sync_i(crtc_v_sync),
        .h_sync_o, .v_sync_o, .video_o
    );

endmodule

//--- rtl/video_dotgen.sv
// ==========================================================
// Dot generator, 8 pixels per character, MSB first
// config_crt_i 0 is the 12-inch CRT, 1 the 9-inch CRT
// ==========================================================
`timescale 1ns/1ps

module video_dotgen (
    input  logic             wb_clock_i,
    input  logic             rst_n_i,
    input  logic             char_clk_en_i,   // Loads the next character
    input  logic             pixel_clk_en_i,  // Shifts one pixel
    input  logic             config_crt_i,
    input  video_pkg::data_t font_i,
    input  logic             reverse_i,
    input  logic             invert_i,
    input  logic             de_i,
    input  video_pkg::ra_t   ra_i,
    input  logic             h_sync_i,
    input  logic             v_sync_i,
    output logic             h_sync_o,
    output logic             v_sync_o,
    output logic             video_o
);
    import video_pkg::*;

    data_t sr;          // Pixel shift register
    logic  rev_q;
    logic  inv_q;
    logic  en_q;        // Displayed and inside the 8-line font
    logic  h_sync_q;
    logic  v_sync_q;
    logic  pixel;

    // Syncs and enable trail the CRTC by one character, matching the fetch
    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sr       <= '0;
            rev_q    <= 1'b0;
            inv_q    <= 1'b0;
            en_q     <= 1'b0;
            h_sync_q <= 1'b0;
            v_sync_q <= 1'b0;
        end else if (char_clk_en_i) begin
            sr       <= font_i;
            rev_q    <= reverse_i;
            inv_q    <= invert_i;
            en_q     <= de_i && !(ra_i[3] || ra_i[4]);      // Raster 8 and up is blank
            h_sync_q <= h_sync_i;
            v_sync_q <= v_sync_i;
        end else if (pixel_clk_en_i) begin
            sr <= {sr[6:0], 1'b0};
        end
    end

    // ma bit 12 low inverts the whole screen
    assign pixel = en_q && (sr[7] ^ rev_q ^ !inv_q);

    // 12-inch wants active high, 9-inch active low
    assign video_o  = pixel ^ config_crt_i;
    assign h_sync_o = h_sync_q ^ config_crt_i;
    assign v_sync_o = v_sync_q ^ config_crt_i;

endmodule

//--- rtl/video_fetch.sv
// ==========================================================
// Wishbone classic read master, code then font byte
// Both reads must finish before the next character enable
// ==========================================================
`timescale 1ns/1ps

module video_fetch (
    input  logic                wb_clock_i,
    input  logic                rst_n_i,
    input  logic                char_clk_en_i,
    input  logic                graphic_i,      // Character set select
    input  video_pkg::ma_t      ma_i,
    input  video_pkg::ra_t      ra_i,
    output video_pkg::wb_addr_t wbm_adr_o,
    input  video_pkg::data_t    wbm_dat_i,
    output logic                wbm_we_o,
    output logic                wbm_cyc_o,
    output logic                wbm_stb_o,
    input  logic                wbm_ack_i,
    output video_pkg::data_t    font_o,         // Font byte for the next character
    output logic                reverse_o,      // Code bit 7
    output logic                invert_o        // ma bit 12
);
    import video_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ_CODE,
        READ_FONT
    } state_t;

    state_t     state;
    logic       start_q;     // CRTC position settles one cycle after the enable
    logic       chr_q;
    logic       gfx_q;
    logic       inv_q;
    logic       rev_q;
    logic [2:0] ra_q;

    assign wbm_we_o = 1'b0;  // Read only

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= IDLE;
            start_q   <= 1'b0;
            wbm_cyc_o <= 1'b0;
            wbm_stb_o <= 1'b0;
            wbm_adr_o <= '0;
            font_o    <= '0;
            reverse_o <= 1'b0;
            invert_o  <= 1'b0;
        end else begin
            start_q <= char_clk_en_i;
            case (state)
                IDLE: begin
                    if (start_q) begin
                        wbm_adr_o <= wb_vram_addr(ma_i[9:0]);
                        wbm_cyc_o <= 1'b1;
                        wbm_stb_o <= 1'b1;
                        state     <= READ_CODE;
                    end
                end
                READ_CODE: begin
                    if (wbm_ack_i) begin                    // Code in, go straight to ROM
                        wbm_adr_o <= wb_vrom_addr(chr_q, gfx_q, wbm_dat_i[6:0], ra_q);
                        state     <= READ_FONT;
                    end
                end
                READ_FONT: begin
                    if (wbm_ack_i) begin
                        font_o    <= wbm_dat_i;
                        reverse_o <= rev_q;
                        invert_o  <= inv_q;
                        wbm_cyc_o <= 1'b0;                  // Cycle end marks results valid
                        wbm_stb_o <= 1'b0;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Position and code bits kept for the font read
    always_ff @(posedge wb_clock_i) begin
        if (state == IDLE && start_q) begin
            chr_q <= ma_i[13];
            gfx_q <= graphic_i;
            inv_q <= ma_i[12];
            ra_q  <= ra_i[2:0];
        end
        if (state == READ_CODE && wbm_ack_i) begin
            rev_q <= wbm_dat_i[7];
        end
    end

    // Address held until the slave acks
    a_adr_stable: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        (wbm_stb_o && !wbm_ack_i) |=> $stable(wbm_adr_o));

endmodule

//--- rtl/video_crtc.sv
// ==========================================================
// 6845-like CRTC, no light pen, cursor or interlace
// Register writes land on the Wishbone ack
// Sync outputs are active high, polarity is fixed downstream
// ==========================================================
`timescale 1ns/1ps

module video_crtc (
    input  logic                 wb_clock_i,
    input  logic                 rst_n_i,
    input  logic                 char_clk_en_i,   // One pulse per character time
    input  video_pkg::reg_addr_t wbs_adr_i,
    input  video_pkg::data_t     wbs_dat_i,
    output video_pkg::data_t     wbs_dat_o,
    input  logic                 wbs_we_i,
    input  logic                 wbs_cyc_i,
    input  logic                 wbs_stb_i,
    output logic                 wbs_ack_o,
    output logic                 de_o,            // Display enable
    output video_pkg::ma_t       ma_o,            // Refresh memory address
    output video_pkg::ra_t       ra_o,            // Raster address
    output logic                 h_sync_o,
    output logic                 v_sync_o
);
    import video_pkg::*;

    data_t r_h_total;
    data_t r_h_displayed;
    data_t r_h_sync_pos;
    data_t r_sync_width;          // Low nibble is the hsync width
    data_t r_v_total;
    data_t r_v_displayed;
    data_t r_v_sync_pos;
    data_t r_max_scan;
    data_t r_start_hi;
    data_t r_start_lo;

    logic       ack_q;
    data_t      h_cnt;            // Character within the line
    data_t      row_cnt;          // Character row within the frame
    ra_t        ra_cnt;           // Raster line within the row
    ma_t        ma_cnt;
    ma_t        row_start;        // Address of the first cell in this row
    logic [4:0] vs_lines;         // Vsync lines still to go

    logic       h_end;
    logic       ra_end;
    logic       row_end;
    logic       vs_start;
    data_t      next_row;
    ma_t        start_addr;
    ma_t        next_row_start;
    logic [8:0] hs_stop;

    // Slave port, ack one cycle after the strobe
    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wbs_cyc_i && wbs_stb_i && !ack_q;
        end
    end

    assign wbs_ack_o = ack_q;

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            r_h_total     <= '0;
            r_h_displayed <= '0;
            r_h_sync_pos  <= '0;
            r_sync_width  <= '0;
            r_v_total     <= '0;
            r_v_displayed <= '0;
            r_v_sync_pos  <= '0;
            r_max_scan    <= '0;
            r_start_hi    <= '0;
            r_start_lo    <= '0;
        end else if (ack_q && wbs_we_i) begin
            case (wbs_adr_i)
                R_H_TOTAL:     r_h_total     <= wbs_dat_i;
                R_H_DISPLAYED: r_h_displayed <= wbs_dat_i;
                R_H_SYNC_POS:  r_h_sync_pos  <= wbs_dat_i;
                R_SYNC_WIDTH:  r_sync_width  <= wbs_dat_i;
                R_V_TOTAL:     r_v_total     <= wbs_dat_i;
                R_V_DISPLAYED: r_v_displayed <= wbs_dat_i;
                R_V_SYNC_POS:  r_v_sync_pos  <= wbs_dat_i;
                R_MAX_SCAN:    r_max_scan    <= wbs_dat_i;
                R_START_HI:    r_start_hi    <= wbs_dat_i;
                R_START_LO:    r_start_lo    <= wbs_dat_i;
                default: ;                                  // Unused index ignores writes
            endcase
        end
    end

    always_comb begin
        case (wbs_adr_i)
            R_H_TOTAL:     wbs_dat_o = r_h_total;
            R_H_DISPLAYED: wbs_dat_o = r_h_displayed;
            R_H_SYNC_POS:  wbs_dat_o = r_h_sync_pos;
            R_SYNC_WIDTH:  wbs_dat_o = r_sync_width;
            R_V_TOTAL:     wbs_dat_o = r_v_total;
            R_V_DISPLAYED: wbs_dat_o = r_v_displayed;
            R_V_SYNC_POS:  wbs_dat_o = r_v_sync_pos;
            R_MAX_SCAN:    wbs_dat_o = r_max_scan;
            R_START_HI:    wbs_dat_o = r_start_hi;
            R_START_LO:    wbs_dat_o = r_start_lo;
            default:       wbs_dat_o = '0;                  // Unused index reads zero
        endcase
    end

    assign h_end          = (h_cnt == r_h_total);
    assign ra_end         = (ra_cnt == r_max_scan[4:0]);
    assign row_end        = (row_cnt == r_v_total);
    assign next_row       = row_end ? '0 : row_cnt + 8'd1;
    assign vs_start       = ra_end && (next_row == r_v_sync_pos);   // Next line opens sync row
    assign start_addr     = {r_start_hi[5:0], r_start_lo};
    assign next_row_start = row_start + ma_t'(r_h_displayed);

    // Counters step once per character time
    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            h_cnt     <= '0;
            row_cnt   <= '0;
            ra_cnt    <= '0;
            ma_cnt    <= '0;
            row_start <= '0;
            vs_lines  <= '0;
        end else if (char_clk_en_i) begin
            if (!h_end) begin
                h_cnt  <= h_cnt + 8'd1;
                ma_cnt <= ma_cnt + 14'd1;
            end else begin
                h_cnt <= '0;
                if (vs_start) begin
                    vs_lines <= 5'd16;                      // Sync spans 16 raster lines
                end else if (vs_lines != 5'd0) begin
                    vs_lines <= vs_lines - 5'd1;
                end
                if (!ra_end) begin
                    ra_cnt <= ra_cnt + 5'd1;
                    ma_cnt <= row_start;                    // Same row again
                end else begin
                    ra_cnt  <= '0;
                    row_cnt <= next_row;
                    if (row_end) begin
                        row_start <= start_addr;            // New frame
                        ma_cnt    <= start_addr;
                    end else begin
                        row_start <= next_row_start;
                        ma_cnt    <= next_row_start;
                    end
                end
            end
        end
    end

    assign hs_stop  = {1'b0, r_h_sync_pos} + 9'(r_sync_width[3:0]);
    assign h_sync_o = (h_cnt >= r_h_sync_pos) && ({1'b0, h_cnt} < hs_stop);
    assign v_sync_o = (vs_lines != 5'd0);
    assign de_o     = (h_cnt < r_h_displayed) && (row_cnt < r_v_displayed);
    assign ma_o     = ma_cnt;
    assign ra_o     = ra_cnt;

    // Master must hold stb until it sees the ack
    a_ack_with_stb: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        wbs_ack_o |-> wbs_stb_i);

endmodule

//--- rtl/video_pkg.sv
// ==========================================================
// Fixed PET memory map, 40-column mode only
// VRAM is 1 KiB at 8000h and the character ROM 4 KiB at C000h
// ==========================================================
package video_pkg;

    typedef logic [7:0]  data_t;        // Bus data byte
    typedef logic [15:0] wb_addr_t;     // Master bus address
    typedef logic [4:0]  reg_addr_t;    // CRTC register index
    typedef logic [13:0] ma_t;          // Refresh address, bit 12 invert, bit 13 alt charset
    typedef logic [4:0]  ra_t;          // Raster line within a row

    // CRTC register indices
    localparam reg_addr_t R_H_TOTAL     = 5'd0;
    localparam reg_addr_t R_H_DISPLAYED = 5'd1;
    localparam reg_addr_t R_H_SYNC_POS  = 5'd2;
    localparam reg_addr_t R_SYNC_WIDTH  = 5'd3;
    localparam reg_addr_t R_V_TOTAL     = 5'd4;
    localparam reg_addr_t R_V_DISPLAYED = 5'd6;
    localparam reg_addr_t R_V_SYNC_POS  = 5'd7;
    localparam reg_addr_t R_MAX_SCAN    = 5'd9;
    localparam reg_addr_t R_START_HI    = 5'd12;
    localparam reg_addr_t R_START_LO    = 5'd13;

    localparam wb_addr_t VRAM_BASE = 16'h8000;     // 1 KiB video RAM
    localparam wb_addr_t VROM_BASE = 16'hC000;     // 4 KiB character ROM

    // Character code address, one byte per cell
    function automatic wb_addr_t wb_vram_addr(input logic [9:0] ma);
        return VRAM_BASE | wb_addr_t'(ma);
    endfunction

    // Font byte address: charset, graphic, code and raster line
    function automatic wb_addr_t wb_vrom_addr(input logic chr_option, input logic graphic,
                                              input logic [6:0] code, input logic [2:0] raster);
        return VROM_BASE | wb_addr_t'({chr_option, graphic, code, raster});
    endfunction

endpackage
